//--- hdl/rv_pkg.sv
/*
   Shared widths and stage records for the four-stage RV32I subset core.
   Only 32-bit words are moved; there are no byte or halfword accesses.
   Opcodes outside opcode_e are legal and execute as no-ops.
*/
package rv_pkg;

   localparam int xlen = 32;                       // datapath and pc width
   localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

   ////////////////////////////////////////////////////////////////////////////
   // encodings

   typedef enum logic [6:0] {
      op_lui    = 7'b0110111,
      op_jal    = 7'b1101111,
      op_branch = 7'b1100011,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_imm    = 7'b0010011,
      op_reg    = 7'b0110011
   } opcode_e;

   // funct3 of the register and immediate ALU groups
   typedef enum logic [2:0] {
      alu_add  = 3'b000,                           // also sub when insn[30] on op_reg
      alu_sll  = 3'b001,
      alu_slt  = 3'b010,
      alu_sltu = 3'b011,
      alu_xor  = 3'b100,
      alu_srl  = 3'b101,                           // also sra when insn[30]
      alu_or   = 3'b110,
      alu_and  = 3'b111
   } alu_fn_e;

   ////////////////////////////////////////////////////////////////////////////
   // stage records

   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      logic [31:0]     insn;
   } fetch_t;

   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      logic [31:0]     insn;
      logic [xlen-1:0] rs1_val;
      logic [xlen-1:0] rs2_val;
   } decode_t;

   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      logic [31:0]     insn;
      logic [4:0]      wb_rd;                      // zero when nothing is written
      logic [xlen-1:0] wb_val;                     // result, or the address of LW/SW
      logic            mem_read;
      logic            mem_write;
      logic [xlen-1:0] store_data;
   } exec_t;

   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      logic [31:0]     insn;
      logic [4:0]      wb_rd;
      logic [xlen-1:0] wb_val;
   } commit_t;

   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
   } redirect_t;

   typedef struct packed {
      logic            valid;
      logic [xlen-3:0] addr;                       // word index into code memory
      logic [31:0]     data;
   } load_t;

endpackage

//--- hdl/rv_fetch.sv
/*
   Fetch stage. The pc steps by 4 each cycle unless a redirect is valid,
   and then the target is fetched on the very next edge.
   The loader may write code memory in any cycle; a fetch of the same word
   in that cycle sees the old contents.
*/
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; #(
   parameter int code_words = 256
) (
   input  logic      clock,
   input  logic      reset,
   input  redirect_t redirect,
   input  load_t     load,
   output fetch_t    fetch
);

   localparam int aw = $clog2(code_words);

   logic [31:0]     code_mem [code_words];
   logic [xlen-1:0] pc;                            // next sequential fetch address
   logic [xlen-1:0] fetch_pc;

   // a redirect bypasses the pc register so the target costs no extra cycle
   assign fetch_pc = redirect.valid ? redirect.pc : pc;

   ////////////////////////////////////////////////////////////////////////////
   // code memory

   always_ff @(posedge clock) begin
      if (load.valid) begin
         code_mem[load.addr[aw-1:0]] <= load.data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // pc and fetch register

   always_ff @(posedge clock) begin
      if (reset) begin
         pc          <= reset_pc;
         fetch.valid <= 1'b0;
      end else begin
         pc          <= fetch_pc + 32'd4;
         fetch.valid <= 1'b1;                      // one instruction every cycle
      end
      fetch.pc   <= fetch_pc;
      fetch.insn <= code_mem[fetch_pc[2 +: aw]];   // word index, low bits ignored
   end

   // loader writes land inside code memory, in reset as well as after it
   load_in_range: assert property (@(posedge clock)
      load.valid |-> load.addr < code_words);

endmodule

//--- hdl/rv_regfile.sv
/*
   Register read stage. x0 is not stored and always reads as zero.
   Reads are write-first against the commit record of the same cycle.
   decode.valid follows fetch and is low from the second reset cycle on.
*/
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
   input  logic    clock,
   input  fetch_t  fetch,
   input  commit_t commit,
   output decode_t decode
);

   logic [xlen-1:0] regs [1:31];
   logic [4:0]      rs1;
   logic [4:0]      rs2;
   logic [xlen-1:0] rs1_val;
   logic [xlen-1:0] rs2_val;
   logic            wr_en;

   assign rs1   = fetch.insn[19:15];
   assign rs2   = fetch.insn[24:20];
   assign wr_en = commit.valid && commit.wb_rd != 5'd0;

   // write-first so an instruction committing now is seen by the reader
   assign rs1_val = (rs1 == 5'd0)                  ? '0 :
                    (wr_en && commit.wb_rd == rs1) ? commit.wb_val :
                                                     regs[rs1];
   assign rs2_val = (rs2 == 5'd0)                  ? '0 :
                    (wr_en && commit.wb_rd == rs2) ? commit.wb_val :
                                                     regs[rs2];

   always_ff @(posedge clock) begin
      if (wr_en) begin
         regs[commit.wb_rd] <= commit.wb_val;
      end
   end

   always_ff @(posedge clock) begin
      decode.valid   <= fetch.valid;               // already cleared by a redirect
      decode.pc      <= fetch.pc;
      decode.insn    <= fetch.insn;
      decode.rs1_val <= rs1_val;
      decode.rs2_val <= rs2_val;
   end

endmodule

//--- hdl/rv_execute.sv
/*
   Execute stage: decode, operand bypass, ALU and branch resolution.
   A load result is not known here, so a consumer right behind a load
   is replayed, as is any instruction while freeze is high.
   Redirect is combinational and lasts one cycle.
*/
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  logic      freeze,
   input  decode_t   decode,
   input  commit_t   commit,
   output exec_t     exec,
   output redirect_t redirect
);

   opcode_e         op;
   alu_fn_e         fn;
   logic [4:0]      rs1;
   logic [4:0]      rs2;
   logic [4:0]      rd;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_s;
   logic [xlen-1:0] imm_b;
   logic [xlen-1:0] imm_j;
   logic [xlen-1:0] imm_u;
   logic [xlen-1:0] a;
   logic [xlen-1:0] b;
   logic [xlen-1:0] alu_b;
   logic [xlen-1:0] alu_out;
   logic [xlen-1:0] target;
   logic [xlen-1:0] result;
   logic            uses_rs1;
   logic            uses_rs2;
   logic            writes_rd;
   logic            lt;
   logic            cond;
   logic            jump;
   logic            load_use;
   logic            active;
   logic            replay;
   logic            squash;                        // drop the entry behind a redirect

   // exec holds the younger of the two results, so it wins
   function automatic logic [xlen-1:0] bypass(input logic [4:0]      r,
                                              input logic [xlen-1:0] rf_val);
      if (r == 5'd0)
         return '0;
      else if (exec.valid && exec.wb_rd == r)
         return exec.wb_val;
      else if (commit.valid && commit.wb_rd == r)
         return commit.wb_val;
      else
         return rf_val;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // decode and operands

   assign op  = opcode_e'(decode.insn[6:0]);
   assign fn  = alu_fn_e'(decode.insn[14:12]);
   assign rs1 = decode.insn[19:15];
   assign rs2 = decode.insn[24:20];
   assign rd  = decode.insn[11:7];

   assign imm_i = {{20{decode.insn[31]}}, decode.insn[31:20]};
   assign imm_s = {{20{decode.insn[31]}}, decode.insn[31:25], decode.insn[11:7]};
   assign imm_b = {{19{decode.insn[31]}}, decode.insn[31], decode.insn[7],
                   decode.insn[30:25], decode.insn[11:8], 1'b0};
   assign imm_j = {{11{decode.insn[31]}}, decode.insn[31], decode.insn[19:12],
                   decode.insn[20], decode.insn[30:21], 1'b0};
   assign imm_u = {decode.insn[31:12], 12'd0};

   assign a = bypass(rs1, decode.rs1_val);         // a load in exec only gives its address
   assign b = bypass(rs2, decode.rs2_val);

   ////////////////////////////////////////////////////////////////////////////
   // ALU and branch compare

   always_comb begin
      alu_b = (op == op_reg) ? b : imm_i;
      case (fn)
         alu_add:  alu_out = (op == op_reg && decode.insn[30]) ? a - alu_b : a + alu_b;
         alu_sll:  alu_out = a << alu_b[4:0];
         alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(alu_b)};
         alu_sltu: alu_out = {{(xlen-1){1'b0}}, a < alu_b};
         alu_xor:  alu_out = a ^ alu_b;
         alu_srl:  alu_out = decode.insn[30] ? $unsigned($signed(a) >>> alu_b[4:0])
                                             : a >> alu_b[4:0];
         alu_or:   alu_out = a | alu_b;
         alu_and:  alu_out = a & alu_b;
         default:  alu_out = '0;
      endcase
   end

   // funct3 bit 2 picks less-than over equal, bit 1 unsigned, bit 0 inverts
   assign lt   = decode.insn[13] ? (a < b) : ($signed(a) < $signed(b));
   assign cond = (decode.insn[14] ? lt : (a == b)) ^ decode.insn[12];

   always_comb begin
      uses_rs1  = 1'b0;
      uses_rs2  = 1'b0;
      writes_rd = 1'b0;
      result    = '0;
      target    = decode.pc + imm_b;
      case (op)
         op_lui: begin
            writes_rd = 1'b1;
            result    = imm_u;
         end
         op_jal: begin
            writes_rd = 1'b1;
            result    = decode.pc + 32'd4;         // link value
            target    = decode.pc + imm_j;
         end
         op_branch: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
         end
         op_load: begin
            uses_rs1  = 1'b1;
            writes_rd = 1'b1;
            result    = a + imm_i;                 // address, data comes from memory
         end
         op_store: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            result   = a + imm_s;
         end
         op_imm: begin
            uses_rs1  = 1'b1;
            writes_rd = 1'b1;
            result    = alu_out;
         end
         op_reg: begin
            uses_rs1  = 1'b1;
            uses_rs2  = 1'b1;
            writes_rd = 1'b1;
            result    = alu_out;
         end
         default: ;                                // unknown opcode, a no-op
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // control flow and replay

   assign jump     = (op == op_jal) || (op == op_branch && cond);
   assign load_use = exec.valid && exec.mem_read && exec.wb_rd != 5'd0 &&
                     ((uses_rs1 && rs1 == exec.wb_rd) || (uses_rs2 && rs2 == exec.wb_rd));
   assign active   = decode.valid && !squash;
   assign replay   = active && (freeze || load_use);

   assign redirect = '{valid: replay || (active && jump),
                       pc:    replay ? decode.pc : target};

   always_ff @(posedge clock) begin
      if (reset) begin
         exec.valid     <= 1'b0;
         exec.mem_read  <= 1'b0;
         exec.mem_write <= 1'b0;
         squash         <= 1'b0;
      end else begin
         exec.valid     <= active && !replay;
         exec.mem_read  <= active && !replay && op == op_load;
         exec.mem_write <= active && !replay && op == op_store;
         squash         <= redirect.valid;
      end
      exec.pc         <= decode.pc;
      exec.insn       <= decode.insn;
      exec.wb_rd      <= writes_rd ? rd : 5'd0;
      exec.wb_val     <= result;
      exec.store_data <= b;
   end

   // the entry that follows a redirect never reaches memory
   no_exec_after_redirect: assert property (@(posedge clock) disable iff (reset)
      redirect.valid |=> ##1 !exec.valid);

   single_access: assert property (@(posedge clock) disable iff (reset)
      exec.valid |-> !(exec.mem_read && exec.mem_write));

endmodule

//--- hdl/rv_memory.sv
/*
   Memory and commit stage. Only LW and SW exist, both word-aligned.
   The address is taken from wb_val; bits above the memory depth wrap.
   A store commits with destination 0 and value 0.
*/
`timescale 1ns/1ps

module rv_memory import rv_pkg::*; #(
   parameter int data_words = 256
) (
   input  logic    clock,
   input  logic    reset,
   input  exec_t   exec,
   output commit_t commit
);

   localparam int aw = $clog2(data_words);

   logic [xlen-1:0] data_mem [data_words];
   logic [aw-1:0]   index;
   logic            store;

   assign index = exec.wb_val[2 +: aw];            // drop the byte offset
   assign store = exec.valid && exec.mem_write;

   always_ff @(posedge clock) begin
      if (store) begin
         data_mem[index] <= exec.store_data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // commit record

   always_ff @(posedge clock) begin
      if (reset) begin
         commit.valid <= 1'b0;
      end else begin
         commit.valid <= exec.valid;
      end
      commit.pc    <= exec.pc;
      commit.insn  <= exec.insn;
      commit.wb_rd <= exec.mem_write ? 5'd0 : exec.wb_rd;
      if (exec.mem_read) begin
         commit.wb_val <= data_mem[index];         // store one cycle earlier is visible
      end else if (exec.mem_write) begin
         commit.wb_val <= '0;
      end else begin
         commit.wb_val <= exec.wb_val;
      end
   end

   word_aligned: assert property (@(posedge clock) disable iff (reset)
      exec.valid && (exec.mem_read || exec.mem_write) |-> exec.wb_val[1:0] == 2'b00);

endmodule

//--- hdl/rv_core.sv
/*
   Four-stage in-order core for a reduced RV32I subset.
   Freeze is the only back-pressure; instructions past execute still commit.
   The code loader is meant to be used while reset is held.
*/
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
   parameter int code_words = 256,
   parameter int data_words = 256
) (
   input  logic            clock,
   input  logic            reset,
   input  logic            freeze,
   input  load_t           load,

   output logic            commit_valid,
   output logic [xlen-1:0] commit_pc,
   output logic [31:0]     commit_insn,
   output logic [4:0]      commit_rd,
   output logic [xlen-1:0] commit_val
);

   fetch_t    fetch;
   fetch_t    fetch_rf;                            // fetch as seen by the register stage
   decode_t   decode;
   exec_t     exec;
   commit_t   commit;
   redirect_t redirect;

   // the instruction in flight is on the wrong path when execute redirects
   assign fetch_rf = '{valid: fetch.valid & ~redirect.valid,
                       pc:    fetch.pc,
                       insn:  fetch.insn};

   ////////////////////////////////////////////////////////////////////////////
   // stages

   rv_fetch #(
      .code_words (code_words)
   ) rv_fetch_inst (
      .clock    (clock),
      .reset    (reset),
      .redirect (redirect),
      .load     (load),
      .fetch    (fetch)
   );

   rv_regfile rv_regfile_inst (
      .clock  (clock),
      .fetch  (fetch_rf),
      .commit (commit),
      .decode (decode)
   );

   rv_execute rv_execute_inst (
      .clock    (clock),
      .reset    (reset),
      .freeze   (freeze),
      .decode   (decode),
      .commit   (commit),
      .exec     (exec),
      .redirect (redirect)
   );

   rv_memory #(
      .data_words (data_words)
   ) rv_memory_inst (
      .clock  (clock),
      .reset  (reset),
      .exec   (exec),
      .commit (commit)
   );

   ////////////////////////////////////////////////////////////////////////////
   // commit trace

   assign commit_valid = commit.valid;
   assign commit_pc    = commit.pc;
   assign commit_insn  = commit.insn;
   assign commit_rd    = commit.wb_rd;
   assign commit_val   = commit.wb_val;

endmodule

//--- dv/core_tb.sv
/*
   Testbench for rv_core. Program and expected commit trace come from
   dv/core_golden.txt, opened relative to the project root.
   The program is loaded one word per cycle while reset is held, so it
   must fit into the reset window.
*/
`timescale 1ns/1ps

module core_tb import rv_pkg::*; ();

   localparam int clock_period = 40;
   localparam int reset_cycles = 10;
   localparam int tail_cycles  = 10;               // watch for stray commits after the last record
   localparam int code_words   = 256;
   localparam int data_words   = 256;

   logic            clock = 1'b0;
   logic            reset;
   logic            freeze;
   load_t           load;
   logic            commit_valid;
   logic [xlen-1:0] commit_pc;
   logic [31:0]     commit_insn;
   logic [4:0]      commit_rd;
   logic [xlen-1:0] commit_val;

   logic [xlen-3:0] prog_idx [$];
   logic [31:0]     prog_word [$];
   commit_t         expected [$];
   logic [xlen-1:0] prog_end_pc = '0;              // first pc past the program
   int              record_count = 0;
   int              seen = 0;
   int              mismatches = 0;
   int              other_errors = 0;
   bit              golden_read = 1'b0;

   rv_core #(
      .code_words (code_words),
      .data_words (data_words)
   ) rv_core_inst (
      .clock        (clock),
      .reset        (reset),
      .freeze       (freeze),
      .load         (load),
      .commit_valid (commit_valid),
      .commit_pc    (commit_pc),
      .commit_insn  (commit_insn),
      .commit_rd    (commit_rd),
      .commit_val   (commit_val)
   );

   always #(clock_period / 2) clock = ~clock;

   ////////////////////////////////////////////////////////////////////////////
   // golden file and reporting

   task automatic read_golden();
      int          fd;
      int          fields;
      string       line;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      commit_t     rec;
      fd = $fopen("dv/core_golden.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("error: cannot open dv/core_golden.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0 && line.getc(0) == "P") begin
            fields = $sscanf(line, "P %h %h", f1, f2);
            if (fields != 2) begin
               other_errors++;
               $display("error: malformed program line in golden file: %s", line);
            end else begin
               prog_idx.push_back(f1[xlen-3:0]);
               prog_word.push_back(f2);
               if ({f1[xlen-3:0], 2'b00} + 32'd4 > prog_end_pc)
                  prog_end_pc = {f1[xlen-3:0], 2'b00} + 32'd4;
            end
         end else if (line.len() > 0 && line.getc(0) == "C") begin
            fields = $sscanf(line, "C %h %h %h %h", f1, f2, f3, f4);
            if (fields != 4) begin
               other_errors++;
               $display("error: malformed commit line in golden file: %s", line);
            end else begin
               rec.valid  = 1'b1;
               rec.pc     = f1;
               rec.insn   = f2;
               rec.wb_rd  = f3[4:0];
               rec.wb_val = f4;
               expected.push_back(rec);
            end
         end
      end
      $fclose(fd);
      record_count = expected.size();
      if (record_count == 0) begin
         other_errors++;
         $display("error: the golden file holds no commit records");
      end
   endtask

   // one record of the trace, field by field
   task automatic check_commit(input commit_t want);
      assert (commit_pc == want.pc) else begin
         mismatches++;
         $display("Mismatch at %0d ns: record %0d commit_pc expected %h got %h",
                  $time, seen, want.pc, commit_pc);
      end
      assert (commit_insn == want.insn) else begin
         mismatches++;
         $display("Mismatch at %0d ns: record %0d commit_insn expected %h got %h",
                  $time, seen, want.insn, commit_insn);
      end
      assert (commit_rd == want.wb_rd) else begin
         mismatches++;
         $display("Mismatch at %0d ns: record %0d commit_rd expected %0d got %0d",
                  $time, seen, want.wb_rd, commit_rd);
      end
      assert (commit_val == want.wb_val) else begin
         mismatches++;
         $display("Mismatch at %0d ns: record %0d commit_val expected %h got %h",
                  $time, seen, want.wb_val, commit_val);
      end
   endtask

   task automatic report_counts();
      $display("commit records %0d of %0d, mismatches %0d, other errors %0d",
               seen, record_count, mismatches, other_errors);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial begin
      int cycle;
      reset <= 1'b1;
      load  <= '0;
      read_golden();
      golden_read = 1'b1;
      if (prog_word.size() > reset_cycles - 1) begin
         other_errors++;
         $display("error: %0d program words do not fit into the reset window", prog_word.size());
      end
      // one loader write per edge from the second reset edge on
      for (cycle = 0; cycle < reset_cycles; cycle++) begin
         @(posedge clock);
         if (cycle < prog_word.size() && cycle < reset_cycles - 1) begin
            load <= '{valid: 1'b1, addr: prog_idx[cycle], data: prog_word[cycle]};
         end else begin
            load <= '0;
         end
      end
      reset <= 1'b0;
      wait (seen >= record_count);
      repeat (tail_cycles) @(posedge clock);
      report_counts();
      if (mismatches == 0 && other_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      freeze <= 1'b0;
      void'($urandom(32'hb04b));
      repeat (reset_cycles) @(posedge clock);
      forever begin
         @(posedge clock);
         freeze <= ($urandom() % 4) == 0;          // high about a quarter of the time
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // commit trace monitor and watchdog

   always @(negedge clock) begin
      if (reset) begin
         assert (!commit_valid) else begin
            other_errors++;
            $display("error at %0d ns: commit_valid is high during reset", $time);
         end
      end else if (commit_valid) begin
         if (seen < record_count) begin
            check_commit(expected[seen]);
            seen++;
         end else begin
            assert (commit_pc >= prog_end_pc) else begin
               other_errors++;
               $display("error at %0d ns: extra commit of pc %h after the last expected record",
                        $time, commit_pc);
            end
         end
      end
   end

   initial begin
      int limit_ns;
      wait (golden_read);
      limit_ns = 8 * record_count * clock_period + 400;
      #(limit_ns);
      other_errors++;
      $display("error: timeout at %0d ns, the commit trace stalled after %0d of %0d records",
               $time, seen, record_count);
      report_counts();
      $display("Test failures found");
      $finish;
   end

endmodule

//--- build.f
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_core.sv
dv/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it, and decides pass or fail
# from the simulation log. Run from anywhere; paths are taken from the project root.

set -u

root_dir="$(cd "$(dirname "$0")" && pwd)"
build_dir="obj_dir"
log_file="sim.log"

cd "$root_dir" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module core_tb -Mdir "$build_dir" -o core_tb -f build.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "run.sh: verilator build failed with status $build_status"
   exit 1
fi

"./$build_dir/core_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "run.sh: simulation exited with status $sim_status"
   exit 1
fi

if grep -qx 'All tests passed!' "$log_file"; then
   echo "run.sh: PASS"
   exit 0
fi

echo "run.sh: FAIL"
exit 1

//--- dv/core_golden.txt
# P <word index> <instruction>            program written through the loader
# C <pc> <insn> <rd> <value>              expected commit records in program order
P 0 876540B7   lui  x1, 0x87654
P 1 00200113   addi x2, x0, 2
P 2 00202623   sw   x2, 12(x0)
P 3 00C02183   lw   x3, 12(x0)
P 4 FFF18113   addi x2, x3, -1
P 5 4020D233   sra  x4, x1, x2
P 6 40220033   sub  x0, x4, x2
P 7 FE0116E3   bne  x2, x0, -20
P 8 008002EF   jal  x5, 8
C 00000000 876540B7 01 87654000
C 00000004 00200113 02 00000002
C 00000008 00202623 00 00000000
C 0000000C 00C02183 03 00000002
C 00000010 FFF18113 02 00000001
C 00000014 4020D233 04 C3B2A000
C 00000018 40220033 00 C3B29FFF
C 0000001C FE0116E3 00 00000000
C 00000008 00202623 00 00000000
C 0000000C 00C02183 03 00000001
C 00000010 FFF18113 02 00000000
C 00000014 4020D233 04 87654000
C 00000018 40220033 00 87654000
C 0000001C FE0116E3 00 00000000
C 00000020 008002EF 05 00000024
